//--- verilog/wb_pkg.sv
package wb_pkg;

    localparam int num_slots = 4;
    localparam int num_regs  = 8;

    // far transfer opcodes load eip and cs together
    localparam int pop_far_jmp  = 36;
    localparam int pop_far_call = 35;
    localparam int pop_far_ret  = 32;

    typedef logic [63:0] data_t;
    typedef logic [31:0] addr_t;
    typedef logic [15:0] sel_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [27:0] fip_t;        // address without low nibble
    typedef logic [36:0] pop_t;
    typedef logic [3:0]  fault_type_t; // msb is external interrupt

    typedef enum logic [1:0] {
        size_8  = 2'b00,
        size_16 = 2'b01,
        size_32 = 2'b10,
        size_64 = 2'b11
    } opsize_e;

endpackage

//--- verilog/wb_result_if.sv
`timescale 1ns/1ns

interface wb_result_if
    import wb_pkg::*;
();

    logic                 valid;              // registered sample valid
    data_t                data [num_slots];
    addr_t                dest [num_slots];
    logic [num_slots-1:0] is_reg;
    logic [num_slots-1:0] is_seg;
    logic [num_slots-1:0] is_mem;
    opsize_e              size;
    logic                 far_op;             // jmp/call/ret far

    modport producer (
        output valid, data, dest, is_reg, is_seg, is_mem, size, far_op
    );

    modport consumer (
        input valid, data, dest, is_reg, is_seg, is_mem, size, far_op
    );

endinterface

//--- verilog/wb_operand_route.sv
`timescale 1ns/1ns

module wb_operand_route
    import wb_pkg::*;
(
    wb_result_if.consumer        res,
    output logic [num_slots-1:0] reg_we,
    output logic [num_slots-1:0] seg_we,
    output reg_idx_t             wr_idx [num_slots],
    output data_t                wr_data [num_slots],
    output opsize_e              wr_size,
    output logic                 mem_ld,
    output addr_t                mem_addr,
    output data_t                mem_data,
    output opsize_e              mem_size
);

    logic [1:0] mem_sel;

    assign reg_we  = res.is_reg & {num_slots{res.valid}};
    assign seg_we  = res.is_seg & {num_slots{res.valid}};
    assign wr_size = res.size;

    always_comb begin
        for (int i = 0; i < num_slots; i++) begin
            wr_idx[i]  = res.dest[i][2:0];
            wr_data[i] = res.data[i];
        end
        if (res.far_op) begin
            wr_data[0] = {48'd0, res.data[0][47:32]}; // selector for cs
        end
    end

    // walk down so the lowest store slot is the one left standing
    always_comb begin
        mem_sel = 2'd0;
        for (int i = num_slots - 1; i >= 0; i--) begin
            if (res.is_mem[i]) begin
                mem_sel = i[1:0];
            end
        end
    end

    assign mem_ld   = res.valid & (|res.is_mem);
    assign mem_addr = res.dest[mem_sel];
    assign mem_data = res.data[mem_sel];
    assign mem_size = res.far_op ? size_64 : res.size; // far op stores eip:cs

endmodule

//--- verilog/wb_branch_resolve.sv
`timescale 1ns/1ns

module wb_branch_resolve
    import wb_pkg::*;
(
    wb_result_if.consumer res,
    input  addr_t         eip_in,
    input  addr_t         br_fip,
    input  addr_t         br_fip_next,
    input  sel_t          cs_in,
    input  logic          br_valid,
    input  logic          br_taken,
    input  logic          br_correct,
    output addr_t         new_eip,
    output sel_t          cs_out,
    output fip_t          fip_even,
    output fip_t          fip_odd,
    output logic          is_resteer
);

    addr_t target;
    fip_t  line_cur;
    fip_t  line_next;

    assign target  = res.far_op ? res.data[0][31:0] : br_fip; // far target in slot 0
    assign new_eip = br_taken ? target : eip_in;
    assign cs_out  = (res.far_op && br_taken) ? res.data[0][47:32] : cs_in;

    assign line_cur  = br_fip[31:4];
    assign line_next = br_fip_next[31:4];

    // odd line index means the pair swaps
    assign fip_even = br_fip[4] ? line_next : line_cur;
    assign fip_odd  = br_fip[4] ? line_cur : line_next;

    assign is_resteer = res.valid & br_valid & ~br_correct; // mispredict

endmodule

//--- verilog/wb_stage.sv
`timescale 1ns/1ns

module wb_stage
    import wb_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  data_t                slot_data [num_slots],
    input  addr_t                slot_dest [num_slots],
    input  logic [num_slots-1:0] slot_is_reg,
    input  logic [num_slots-1:0] slot_is_seg,
    input  logic [num_slots-1:0] slot_is_mem,
    input  opsize_e              res_size,
    input  pop_t                 p_op,
    input  logic                 ie_in,
    input  logic [2:0]           ie_type_in,
    input  logic                 interrupt_in,
    input  addr_t                eip_in,
    input  sel_t                 cs_in,
    input  addr_t                br_fip,
    input  addr_t                br_fip_next,
    input  logic                 br_valid,
    input  logic                 br_taken,
    input  logic                 br_correct,
    output addr_t                eip_r,
    output sel_t                 cs_r,
    output addr_t                br_fip_r,
    output addr_t                br_fip_next_r,
    output logic                 br_valid_r,
    output logic                 br_taken_r,
    output logic                 br_correct_r,
    output logic                 fault_valid,
    output fault_type_t          fault_type,
    wb_result_if.producer        res
);

    logic       ie_r;
    logic       int_r;
    logic [2:0] ie_type_r;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res.valid <= 1'b0;
        end else begin
            res.valid <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        res.data      <= slot_data;
        res.dest      <= slot_dest;
        res.is_reg    <= slot_is_reg;
        res.is_seg    <= slot_is_seg;
        res.is_mem    <= slot_is_mem;
        res.size      <= res_size;
        res.far_op    <= p_op[pop_far_jmp] | p_op[pop_far_call] | p_op[pop_far_ret];
        ie_r          <= ie_in;
        int_r         <= interrupt_in;
        ie_type_r     <= ie_type_in;
        eip_r         <= eip_in;
        cs_r          <= cs_in;
        br_fip_r      <= br_fip;
        br_fip_next_r <= br_fip_next;
        br_valid_r    <= br_valid;
        br_taken_r    <= br_taken;
        br_correct_r  <= br_correct;
    end

    assign fault_valid = res.valid & (ie_r | int_r);
    assign fault_type  = {int_r, ie_type_r}; // interrupt flag over class

endmodule

//--- verilog/wb_regfile.sv
`timescale 1ns/1ns

module wb_regfile
    import wb_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [num_slots-1:0] reg_we,
    input  logic [num_slots-1:0] seg_we,
    input  reg_idx_t             wr_idx [num_slots],
    input  data_t                wr_data [num_slots],
    input  opsize_e              wr_size,
    input  reg_idx_t             rd_idx,
    output data_t                rd_data,
    input  reg_idx_t             seg_rd_idx,
    output sel_t                 seg_rd_data
);

    data_t gpr [num_regs];
    sel_t  seg [num_regs];

    function automatic data_t size_merge(data_t old_val, data_t new_val, opsize_e size);
        data_t merged;
        merged = old_val;
        case (size)
            size_8:  merged[7:0]  = new_val[7:0];
            size_16: merged[15:0] = new_val[15:0];
            size_32: merged[31:0] = new_val[31:0];
            size_64: merged       = new_val;
        endcase
        return merged;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < num_regs; r++) begin
                gpr[r] <= '0;
                seg[r] <= '0;
            end
        end else begin
            for (int i = 0; i < num_slots; i++) begin // higher slot lands last
                if (reg_we[i]) begin
                    gpr[wr_idx[i]] <= size_merge(gpr[wr_idx[i]], wr_data[i], wr_size);
                end
                if (seg_we[i]) begin
                    seg[wr_idx[i]] <= wr_data[i][15:0];
                end
            end
        end
    end

    assign rd_data     = gpr[rd_idx];
    assign seg_rd_data = seg[seg_rd_idx];

endmodule

//--- verilog/writeback_top.sv
`timescale 1ns/1ns

module writeback_top
    import wb_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 valid_in,
    input  data_t                slot_data [num_slots],
    input  addr_t                slot_dest [num_slots],
    input  logic [num_slots-1:0] slot_is_reg,
    input  logic [num_slots-1:0] slot_is_seg,
    input  logic [num_slots-1:0] slot_is_mem,
    input  opsize_e              res_size,
    input  pop_t                 p_op,
    input  logic                 ie_in,
    input  logic [2:0]           ie_type_in,
    input  logic                 interrupt_in,
    input  addr_t                eip_in,
    input  sel_t                 cs_in,
    input  addr_t                br_fip,
    input  addr_t                br_fip_next,
    input  logic                 br_valid,
    input  logic                 br_taken,
    input  logic                 br_correct,
    input  reg_idx_t             rd_idx,
    output data_t                rd_data,
    input  reg_idx_t             seg_rd_idx,
    output sel_t                 seg_rd_data,
    output logic                 valid_out,
    output logic                 mem_ld,
    output addr_t                mem_addr,
    output data_t                mem_data,
    output opsize_e              mem_size,
    output addr_t                new_eip,
    output sel_t                 cs_out,
    output fip_t                 fip_even,
    output fip_t                 fip_odd,
    output logic                 is_resteer,
    output logic                 fault_valid,
    output fault_type_t          fault_type
);

    logic [num_slots-1:0] reg_we;
    logic [num_slots-1:0] seg_we;
    reg_idx_t             wr_idx [num_slots];
    data_t                wr_data [num_slots];
    opsize_e              wr_size;
    addr_t                eip_r;
    sel_t                 cs_r;
    addr_t                br_fip_r;
    addr_t                br_fip_next_r;
    logic                 br_valid_r;
    logic                 br_taken_r;
    logic                 br_correct_r;

    wb_result_if res ();

    assign valid_out = res.valid;

    wb_stage u_stage (
        .clk           (clk),
        .arst_n        (arst_n),
        .valid_in      (valid_in),
        .slot_data     (slot_data),
        .slot_dest     (slot_dest),
        .slot_is_reg   (slot_is_reg),
        .slot_is_seg   (slot_is_seg),
        .slot_is_mem   (slot_is_mem),
        .res_size      (res_size),
        .p_op          (p_op),
        .ie_in         (ie_in),
        .ie_type_in    (ie_type_in),
        .interrupt_in  (interrupt_in),
        .eip_in        (eip_in),
        .cs_in         (cs_in),
        .br_fip        (br_fip),
        .br_fip_next   (br_fip_next),
        .br_valid      (br_valid),
        .br_taken      (br_taken),
        .br_correct    (br_correct),
        .eip_r         (eip_r),
        .cs_r          (cs_r),
        .br_fip_r      (br_fip_r),
        .br_fip_next_r (br_fip_next_r),
        .br_valid_r    (br_valid_r),
        .br_taken_r    (br_taken_r),
        .br_correct_r  (br_correct_r),
        .fault_valid   (fault_valid),
        .fault_type    (fault_type),
        .res           (res.producer)
    );

    wb_operand_route u_route (
        .res      (res.consumer),
        .reg_we   (reg_we),
        .seg_we   (seg_we),
        .wr_idx   (wr_idx),
        .wr_data  (wr_data),
        .wr_size  (wr_size),
        .mem_ld   (mem_ld),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .mem_size (mem_size)
    );

    wb_branch_resolve u_branch (
        .res         (res.consumer),
        .eip_in      (eip_r),
        .br_fip      (br_fip_r),
        .br_fip_next (br_fip_next_r),
        .cs_in       (cs_r),
        .br_valid    (br_valid_r),
        .br_taken    (br_taken_r),
        .br_correct  (br_correct_r),
        .new_eip     (new_eip),
        .cs_out      (cs_out),
        .fip_even    (fip_even),
        .fip_odd     (fip_odd),
        .is_resteer  (is_resteer)
    );

    wb_regfile u_regfile (
        .clk         (clk),
        .arst_n      (arst_n),
        .reg_we      (reg_we),
        .seg_we      (seg_we),
        .wr_idx      (wr_idx),
        .wr_data     (wr_data),
        .wr_size     (wr_size),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .seg_rd_idx  (seg_rd_idx),
        .seg_rd_data (seg_rd_data)
    );

endmodule

//--- verif/wb_tb.sv
`timescale 1ns/1ns

module wb_tb;
    import wb_pkg::*;

    logic                 clk;
    logic                 arst_n;
    logic                 valid_in;
    data_t                slot_data [num_slots];
    addr_t                slot_dest [num_slots];
    logic [num_slots-1:0] slot_is_reg, slot_is_seg, slot_is_mem;
    opsize_e              res_size;
    pop_t                 p_op;
    logic                 ie_in, interrupt_in;
    logic [2:0]           ie_type_in;
    addr_t                eip_in, br_fip, br_fip_next;
    sel_t                 cs_in;
    logic                 br_valid, br_taken, br_correct;
    reg_idx_t             rd_idx, seg_rd_idx;
    data_t                rd_data, mem_data;
    sel_t                 seg_rd_data, cs_out;
    logic                 valid_out, mem_ld, is_resteer, fault_valid;
    addr_t                mem_addr, new_eip;
    opsize_e              mem_size;
    fip_t                 fip_even, fip_odd;
    fault_type_t          fault_type;

    integer      seed = 50;
    int          cycle_n = 0;
    data_t       gpr_m [num_regs];    // architectural state seen now
    data_t       gpr_next [num_regs]; // after the sample in flight is written
    sel_t        seg_m [num_regs];
    sel_t        seg_next [num_regs];
    logic        exp_valid, exp_mem_ld, exp_resteer, exp_fault;
    addr_t       exp_mem_addr, exp_eip;
    data_t       exp_mem_data;
    opsize_e     exp_mem_size;
    sel_t        exp_cs;
    fip_t        exp_even, exp_odd;
    fault_type_t exp_fault_type;

    writeback_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic init_inputs();
        arst_n       = 1'b0;
        valid_in     = 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            slot_data[i] <= '0;
            slot_dest[i] <= '0;
        end
        slot_is_reg  = '0;
        slot_is_seg  = '0;
        slot_is_mem  = '0;
        res_size     = size_8;
        p_op         = '0;
        ie_in        = 1'b0;
        ie_type_in   = '0;
        interrupt_in = 1'b0;
        eip_in       = '0;
        cs_in        = '0;
        br_fip       = '0;
        br_fip_next  = '0;
        br_valid     = 1'b0;
        br_taken     = 1'b0;
        br_correct   = 1'b0;
        rd_idx       = '0;
        seg_rd_idx   = '0;
        for (int r = 0; r < num_regs; r++) begin
            gpr_m[r] = '0;
            seg_m[r] = '0;
        end
    endtask

    // expected results of the sample the DUT takes at this edge
    task automatic compute_expect();
        logic     far;
        logic     found;
        fip_t     line;
        data_t    mask;
        data_t    d;
        reg_idx_t idx;
        far        = p_op[pop_far_jmp] | p_op[pop_far_call] | p_op[pop_far_ret];
        exp_valid  = valid_in;
        exp_mem_ld = valid_in && slot_is_mem != '0;
        found      = 1'b0;
        for (int i = 0; i < num_slots; i++) begin
            if (slot_is_mem[i] && !found) begin
                found        = 1'b1;
                exp_mem_addr = slot_dest[i];
                exp_mem_data = slot_data[i];
            end
        end
        exp_mem_size   = far ? size_64 : res_size;
        exp_eip        = !br_taken ? eip_in : (far ? slot_data[0][31:0] : br_fip);
        exp_cs         = (far && br_taken) ? slot_data[0][47:32] : cs_in;
        line           = br_fip[31:4];
        exp_even       = line[0] ? br_fip_next[31:4] : line;
        exp_odd        = line[0] ? line : br_fip_next[31:4];
        exp_resteer    = valid_in && br_valid && !br_correct;
        exp_fault      = valid_in && (ie_in || interrupt_in);
        exp_fault_type = {interrupt_in, ie_type_in};
        mask           = {64{1'b1}} >> (64 - (8 << res_size)); // low bytes the size covers
        gpr_next       = gpr_m;
        seg_next       = seg_m;
        for (int i = 0; i < num_slots; i++) begin
            d   = (far && i == 0) ? {48'd0, slot_data[0][47:32]} : slot_data[i];
            idx = slot_dest[i][2:0];
            if (valid_in && slot_is_reg[i]) begin
                gpr_next[idx] = (gpr_next[idx] & ~mask) | (d & mask);
            end
            if (valid_in && slot_is_seg[i]) begin
                seg_next[idx] = d[15:0];
            end
        end
    endtask

    task automatic drive_stim(input bit random_valid, input int parity);
        logic [31:0] r;
        logic [31:0] s;
        addr_t       fip;
        r   = rand32();
        s   = rand32();
        fip = rand32();
        if (parity == 0 || parity == 1) begin
            fip[4] = parity[0];
        end
        valid_in <= random_valid & (r[0] | r[1]);
        for (int i = 0; i < num_slots; i++) begin
            slot_data[i] <= {rand32(), rand32()};
            slot_dest[i] <= rand32();
        end
        slot_is_reg  <= r[5:2];
        slot_is_seg  <= r[9:6] & r[13:10];
        slot_is_mem  <= r[17:14] & {num_slots{r[18]}};
        res_size     <= opsize_e'(r[20:19]);
        p_op         <= {r[21] & r[22], r[23] & r[24], r[25], r[26], r[27] & r[28], rand32()};
        ie_in        <= r[29] & r[30];
        interrupt_in <= r[31] & s[0];
        ie_type_in   <= s[3:1];
        br_valid     <= s[4];
        br_taken     <= s[5];
        br_correct   <= s[6];
        eip_in       <= rand32();
        cs_in        <= s[31:16];
        br_fip       <= fip;
        br_fip_next  <= fip + 32'd16; // next sequential line
        rd_idx       <= reg_idx_t'(cycle_n);
        seg_rd_idx   <= reg_idx_t'(cycle_n + 5);
        cycle_n++;
    endtask

    task automatic check_outputs();
        check(64'(valid_out), 64'(exp_valid), "valid_out");
        check(64'(mem_ld), 64'(exp_mem_ld), "mem_ld");
        if (exp_mem_ld) begin
            check(64'(mem_addr), 64'(exp_mem_addr), "mem_addr");
            check(mem_data, exp_mem_data, "mem_data");
        end
        check(64'(mem_size), 64'(exp_mem_size), "mem_size");
        check(64'(new_eip), 64'(exp_eip), "new_eip");
        check(64'(cs_out), 64'(exp_cs), "cs_out");
        check(64'(fip_even), 64'(exp_even), "fip_even");
        check(64'(fip_odd), 64'(exp_odd), "fip_odd");
        check(64'(is_resteer), 64'(exp_resteer), "is_resteer");
        check(64'(fault_valid), 64'(exp_fault), "fault_valid");
        check(64'(fault_type), 64'(exp_fault_type), "fault_type");
        check(rd_data, gpr_m[rd_idx], "rd_data");
        check(64'(seg_rd_data), 64'(seg_m[seg_rd_idx]), "seg_rd_data");
        gpr_m = gpr_next;
        seg_m = seg_next;
    endtask

    task automatic run_cycle(input bit random_valid, input int parity);
        @(posedge clk);
        compute_expect();
        drive_stim(random_valid, parity);
        @(negedge clk); // outputs settled mid cycle
        check_outputs();
    endtask

    initial begin
        init_inputs();
        for (int i = 0; i < 5; i++) begin
            @(posedge clk);
            rd_idx     <= reg_idx_t'(i);
            seg_rd_idx <= reg_idx_t'(i + 3);
            if (i == 4) begin
                arst_n <= 1'b1;
            end
            @(negedge clk);
            check(64'(valid_out), 64'd0, "valid_out in reset");
            check(64'(mem_ld), 64'd0, "mem_ld in reset");
            check(64'(is_resteer), 64'd0, "is_resteer in reset");
            check(64'(fault_valid), 64'd0, "fault_valid in reset");
            check(rd_data, 64'd0, "rd_data in reset");
            check(64'(seg_rd_data), 64'd0, "seg_rd_data in reset");
        end
        repeat (8) run_cycle(1'b0, 2); // all registers still zero
        repeat (600) run_cycle(1'b1, 2);
        for (int p = 0; p < 4; p++) begin
            run_cycle(1'b1, p % 2);
        end
        repeat (40) run_cycle(1'b0, 2);
        repeat (200) run_cycle(1'b1, 2);
        repeat (8) run_cycle(1'b0, 2);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- compile.f
verilog/wb_pkg.sv
verilog/wb_result_if.sv
verilog/wb_operand_route.sv
verilog/wb_branch_resolve.sv
verilog/wb_stage.sv
verilog/wb_regfile.sv
verilog/writeback_top.sv
verif/wb_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f compile.f --top-module wb_tb -o wb_sim

# a $fatal in the testbench gives a failing exit status
./obj_dir/wb_sim
